/* alu_params.svh */
// datapath parameters: data width and register count of the ALU slice
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// ----------------------------------------------------------------------
// data width
// ----------------------------------------------------------------------

// signed operand and result width
`define ALU_BW 8

// ----------------------------------------------------------------------
// register file
// ----------------------------------------------------------------------

// fixed by the 2-bit rd/ra/rb instruction fields
`define ALU_REGS 4

`endif

/* alu_pkg.sv */
// datapath package: opcode encoding and the structs passed between stages
`include "alu_params.svh"

package alu_pkg;

  // ----------------------------------------------------------------------
  // opcodes
  // ----------------------------------------------------------------------
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_INC  = 3'd5,
    OP_MOVA = 3'd6,
    OP_MOVB = 3'd7
  } alu_op_e;

  // ----------------------------------------------------------------------
  // stage payloads
  // ----------------------------------------------------------------------

  // instruction word as strobed in by the issuer, msb first
  typedef struct packed {
    alu_op_e            op;
    logic               use_imm;
    logic [1:0]         rd;
    logic [1:0]         ra;
    logic [1:0]         rb;
    logic [`ALU_BW-1:0] imm;
  } instr_t;

  // decoder to execute
  typedef struct packed {
    logic               valid;
    alu_op_e            op;
    logic               use_imm;
    logic [1:0]         rd;
    logic [1:0]         ra;
    logic [1:0]         rb;
    logic [`ALU_BW-1:0] imm;
  } decoded_t;

  // execute to result
  typedef struct packed {
    logic               valid;
    logic [1:0]         rd;
    logic [`ALU_BW-1:0] result;
    logic               overflow;
  } exec_t;

  // same bit order as the original alu flags port
  typedef struct packed {
    logic overflow;
    logic negative;
    logic zero;
  } flags_t;

endpackage

/* cl_adder.sv */
// carry-lookahead adder with optional subtract
`timescale 1ns/1ns
`include "alu_params.svh"

module cl_adder #(
  parameter int Width = `ALU_BW
) (
  input  logic [Width-1:0] a_i,
  input  logic [Width-1:0] b_i,
  input  logic             sub_i,
  output logic [Width-1:0] sum_o,
  output logic             c_o
);

  logic [Width-1:0] b_eff;
  logic [Width-1:0] gen;
  logic [Width-1:0] prop;
  logic [Width:0]   carry;

  // subtract as a + ~b + 1
  assign b_eff    = sub_i ? ~b_i : b_i;
  assign gen      = a_i & b_eff;
  assign prop     = a_i ^ b_eff;

  // ----------------------------------------------------------------------
  // lookahead carries
  // ----------------------------------------------------------------------

  // each carry expanded as g_i | p_i g_i-1 | ... | p_i..p_0 c_0
  always_comb begin
    logic prop_chain;
    // carry in is the subtract control
    carry[0] = sub_i;
    for (int i = 0; i < Width; i++) begin
      carry[i+1] = gen[i];
      prop_chain = prop[i];
      for (int j = i - 1; j >= 0; j--) begin
        carry[i+1] = carry[i+1] | (prop_chain & gen[j]);
        prop_chain = prop_chain & prop[j];
      end
      carry[i+1] = carry[i+1] | (prop_chain & carry[0]);
    end
  end

  assign sum_o = prop ^ carry[Width-1:0];
  assign c_o   = carry[Width];

endmodule

/* alu.sv */
// signed ALU: eight operations with overflow detection
`timescale 1ns/1ns
`include "alu_params.svh"

module alu
  import alu_pkg::*;
#(
  parameter int BW = `ALU_BW
) (
  input  logic signed [BW-1:0] in_a_i,
  input  logic signed [BW-1:0] in_b_i,
  input  alu_op_e              opcode_i,
  output logic signed [BW-1:0] out_o,
  output logic                 overflow_o
);

  logic [BW-1:0] out_addsub;
  logic [BW-1:0] out_inc;
  logic          is_sub;
  logic          a_is_max;

  // ----------------------------------------------------------------------
  // arithmetic
  // ----------------------------------------------------------------------

  // one adder covers add and sub
  assign is_sub = (opcode_i == OP_SUB);

  cl_adder #(
    .Width(BW)
  ) u_addsub (
    .a_i  (in_a_i),
    .b_i  (in_b_i),
    .sub_i(is_sub),
    .sum_o(out_addsub),
    .c_o  ()
  );

  // increment of a
  cl_adder #(
    .Width(BW)
  ) u_inc (
    .a_i  (in_a_i),
    .b_i  (BW'(1)),
    .sub_i(1'b0),
    .sum_o(out_inc),
    .c_o  ()
  );

  // ----------------------------------------------------------------------
  // result select
  // ----------------------------------------------------------------------
  always_comb begin
    case (opcode_i)
      OP_ADD:  out_o = out_addsub;
      OP_SUB:  out_o = out_addsub;
      OP_AND:  out_o = in_a_i & in_b_i;
      OP_OR:   out_o = in_a_i | in_b_i;
      OP_XOR:  out_o = in_a_i ^ in_b_i;
      OP_INC:  out_o = out_inc;
      OP_MOVA: out_o = in_a_i;
      OP_MOVB: out_o = in_b_i;
      default: out_o = '0;
    endcase
  end

  // ----------------------------------------------------------------------
  // overflow
  // ----------------------------------------------------------------------

  // largest positive value, 0111..1
  assign a_is_max = (in_a_i == {1'b0, {(BW-1){1'b1}}});

  always_comb begin
    case (opcode_i)
      // same signs in, different sign out
      OP_ADD:  overflow_o = (in_a_i[BW-1] == in_b_i[BW-1]) &&
                            (out_addsub[BW-1] != in_a_i[BW-1]);
      // opposite signs in, difference flips away from a
      OP_SUB:  overflow_o = (in_a_i[BW-1] != in_b_i[BW-1]) &&
                            (out_addsub[BW-1] != in_a_i[BW-1]);
      OP_INC:  overflow_o = a_is_max;
      // logic and moves never overflow
      default: overflow_o = 1'b0;
    endcase
  end

endmodule

/* instr_decoder.sv */
// instruction decoder: captures a strobed instruction and splits its fields
`timescale 1ns/1ns
`include "alu_params.svh"

module instr_decoder
  import alu_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     instr_valid_i,
  input  instr_t   instr_i,
  output decoded_t dec_o
);

  // ----------------------------------------------------------------------
  // decode register
  // ----------------------------------------------------------------------

  // strobe re-sampled every cycle and fields only on a new instruction
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dec_o <= '0;
    end else begin
      dec_o.valid <= instr_valid_i;
      if (instr_valid_i) begin
        dec_o.op      <= instr_i.op;
        dec_o.use_imm <= instr_i.use_imm;
        dec_o.rd      <= instr_i.rd;
        dec_o.ra      <= instr_i.ra;
        dec_o.rb      <= instr_i.rb;
        dec_o.imm     <= instr_i.imm;
      end
    end
  end

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------

  // one decoded item per strobe exactly one cycle later
  property p_valid_follows_strobe;
    @(posedge clk_i) disable iff (!rst_n_i)
      $past(rst_n_i) |-> (dec_o.valid == $past(instr_valid_i));
  endproperty

  a_valid_follows_strobe : assert property (p_valid_follows_strobe)
    else $error("decoder valid does not track the instruction strobe");

endmodule

/* reg_file.sv */
// register file: four entries, two combinational reads and one synchronous write
`timescale 1ns/1ns
`include "alu_params.svh"

module reg_file (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic [1:0]         rd_addr_a_i,
  input  logic [1:0]         rd_addr_b_i,
  output logic [`ALU_BW-1:0] rd_data_a_o,
  output logic [`ALU_BW-1:0] rd_data_b_o,
  input  logic               wr_en_i,
  input  logic [1:0]         wr_addr_i,
  input  logic [`ALU_BW-1:0] wr_data_i
);

  // register storage, cleared so that every read after reset is zero
  logic [`ALU_BW-1:0] regs_q [`ALU_REGS];

  // ----------------------------------------------------------------------
  // write port
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `ALU_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i) begin
      regs_q[wr_addr_i] <= wr_data_i;
    end
  end

  // ----------------------------------------------------------------------
  // read ports
  // ----------------------------------------------------------------------

  // no bypass, a write lands at the edge before the dependent read
  assign rd_data_a_o = regs_q[rd_addr_a_i];
  assign rd_data_b_o = regs_q[rd_addr_b_i];

  // written data and address must be known, it would poison later reads
  a_wr_known : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      wr_en_i |-> !$isunknown({wr_addr_i, wr_data_i})
  ) else $error("register write with unknown address or data");

endmodule

/* exec_stage.sv */
// execute stage: operand read, ALU, register writeback and execute register
`timescale 1ns/1ns
`include "alu_params.svh"

module exec_stage
  import alu_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  decoded_t           dec_i,
  output logic [1:0]         rd_addr_a_o,
  output logic [1:0]         rd_addr_b_o,
  input  logic [`ALU_BW-1:0] rd_data_a_i,
  input  logic [`ALU_BW-1:0] rd_data_b_i,
  output logic               wr_en_o,
  output logic [1:0]         wr_addr_o,
  output logic [`ALU_BW-1:0] wr_data_o,
  output exec_t              exec_o
);

  logic [`ALU_BW-1:0] opnd_b;
  logic [`ALU_BW-1:0] alu_out;
  logic               alu_ovf;

  // operand fetch straight from the decoded fields
  assign rd_addr_a_o = dec_i.ra;
  assign rd_addr_b_o = dec_i.rb;

  // immediate replaces b so movb with imm acts as a load
  assign opnd_b = dec_i.use_imm ? dec_i.imm : rd_data_b_i;

  alu #(
    .BW(`ALU_BW)
  ) u_alu (
    .in_a_i    (rd_data_a_i),
    .in_b_i    (opnd_b),
    .opcode_i  (dec_i.op),
    .out_o     (alu_out),
    .overflow_o(alu_ovf)
  );

  // ----------------------------------------------------------------------
  // writeback lands at the same edge as the execute register
  // ----------------------------------------------------------------------
  assign wr_en_o   = dec_i.valid;
  assign wr_addr_o = dec_i.rd;
  assign wr_data_o = alu_out;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exec_o <= '0;
    end else begin
      exec_o.valid <= dec_i.valid;
      if (dec_i.valid) begin
        exec_o.rd       <= dec_i.rd;
        exec_o.result   <= alu_out;
        exec_o.overflow <= alu_ovf;
      end
    end
  end

  // a write always belongs to a decoded item
  a_wr_has_item : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      wr_en_o |-> dec_i.valid
  ) else $error("register write without a decoded item");

endmodule

/* result_stage.sv */
// result stage: completes the flags and publishes each result with its strobe
`timescale 1ns/1ns
`include "alu_params.svh"

module result_stage
  import alu_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  exec_t              exec_i,
  output logic               result_valid_o,
  output logic [`ALU_BW-1:0] result_o,
  output logic [1:0]         result_rd_o,
  output flags_t             flags_o
);

  flags_t flags_d;

  // ----------------------------------------------------------------------
  // flag completion
  // ----------------------------------------------------------------------

  // overflow comes from the ALU, the rest from the result value
  assign flags_d.overflow = exec_i.overflow;
  assign flags_d.negative = exec_i.result[`ALU_BW-1];
  assign flags_d.zero     = (exec_i.result == '0);

  // ----------------------------------------------------------------------
  // output register
  // ----------------------------------------------------------------------

  // payload holds between strobes
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      result_valid_o <= 1'b0;
      result_o       <= '0;
      result_rd_o    <= '0;
      flags_o        <= '0;
    end else begin
      result_valid_o <= exec_i.valid;
      if (exec_i.valid) begin
        result_o    <= exec_i.result;
        result_rd_o <= exec_i.rd;
        flags_o     <= flags_d;
      end
    end
  end

endmodule

/* datapath_top.sv */
// datapath top: decoder, register file, execute and result stages
`timescale 1ns/1ns
`include "alu_params.svh"

module datapath_top
  import alu_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               instr_valid_i,
  input  instr_t             instr_i,
  output logic               result_valid_o,
  output logic [`ALU_BW-1:0] result_o,
  output logic [1:0]         result_rd_o,
  output flags_t             flags_o
);

  decoded_t           dec;
  exec_t              exe;
  logic [1:0]         rd_addr_a;
  logic [1:0]         rd_addr_b;
  logic [`ALU_BW-1:0] rd_data_a;
  logic [`ALU_BW-1:0] rd_data_b;
  logic               wr_en;
  logic [1:0]         wr_addr;
  logic [`ALU_BW-1:0] wr_data;

  // ----------------------------------------------------------------------
  // stage 1, decode
  // ----------------------------------------------------------------------
  instr_decoder u_dec (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .instr_valid_i(instr_valid_i),
    .instr_i      (instr_i),
    .dec_o        (dec)
  );

  // ----------------------------------------------------------------------
  // stage 2, execute and writeback
  // ----------------------------------------------------------------------
  reg_file u_rf (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rd_addr_a_i(rd_addr_a),
    .rd_addr_b_i(rd_addr_b),
    .rd_data_a_o(rd_data_a),
    .rd_data_b_o(rd_data_b),
    .wr_en_i    (wr_en),
    .wr_addr_i  (wr_addr),
    .wr_data_i  (wr_data)
  );

  exec_stage u_exec (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .dec_i      (dec),
    .rd_addr_a_o(rd_addr_a),
    .rd_addr_b_o(rd_addr_b),
    .rd_data_a_i(rd_data_a),
    .rd_data_b_i(rd_data_b),
    .wr_en_o    (wr_en),
    .wr_addr_o  (wr_addr),
    .wr_data_o  (wr_data),
    .exec_o     (exe)
  );

  // ----------------------------------------------------------------------
  // stage 3, result and flags
  // ----------------------------------------------------------------------
  result_stage u_res (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .exec_i        (exe),
    .result_valid_o(result_valid_o),
    .result_o      (result_o),
    .result_rd_o   (result_rd_o),
    .flags_o       (flags_o)
  );

endmodule

/* tb_clkgen.sv */
// testbench clock and reset generator: 10 ns clock, reset low for 4 cycles
`timescale 1ns/1ns

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  // free-running clock, 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset held over 4 rising edges, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* tb_datapath.sv */
// datapath testbench: directed and random instructions checked against a register model
`timescale 1ns/1ns
`include "alu_params.svh"

module tb_datapath
  import alu_pkg::*;
();

  typedef logic [`ALU_BW-1:0] word_t;

  // one expected result due at a given falling edge
  typedef struct packed {
    logic [31:0] due;
    logic [1:0]  rd;
    word_t       result;
    flags_t      flags;
  } expect_t;

  localparam int Timeout = 50;
  localparam int MaxVal  = (1 << (`ALU_BW - 1)) - 1;
  localparam int MinVal  = -(1 << (`ALU_BW - 1));

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  instr_t      instr;
  logic        result_valid;
  word_t       result;
  logic [1:0]  result_rd;
  flags_t      flags;
  word_t       model [`ALU_REGS];
  expect_t     pending [$];
  logic [31:0] cycle;
  int          errors;
  int          timeouts;

  tb_clkgen u_clkgen (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  datapath_top DUT (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .result_valid_o(result_valid),
    .result_o      (result),
    .result_rd_o   (result_rd),
    .flags_o       (flags)
  );

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------

  // wide signed result then truncated
  // overflow means out of signed range
  function automatic expect_t predict(input alu_op_e op, input word_t a, input word_t b,
                                      input logic [1:0] rd);
    expect_t e;
    int      sa;
    int      sb;
    int      wide;
    sa = int'($signed(a));
    sb = int'($signed(b));
    case (op)
      OP_ADD:  wide = sa + sb;
      OP_SUB:  wide = sa - sb;
      OP_INC:  wide = sa + 1;
      OP_AND:  wide = sa & sb;
      OP_OR:   wide = sa | sb;
      OP_XOR:  wide = sa ^ sb;
      OP_MOVA: wide = sa;
      default: wide = sb;
    endcase
    e.result         = wide[`ALU_BW-1:0];
    e.flags.overflow = (op inside {OP_ADD, OP_SUB, OP_INC}) && (wide > MaxVal || wide < MinVal);
    e.flags.negative = e.result[`ALU_BW-1];
    e.flags.zero     = (e.result == '0);
    e.rd             = rd;
    // captured at the next rising edge and out after the third
    e.due            = cycle + 3;
    return e;
  endfunction

  // ----------------------------------------------------------------------
  // checking
  // ----------------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Fail at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  // one pulse exactly when the queue head is due
  task automatic check_outputs();
    expect_t head;
    logic    due_now;
    due_now = (pending.size() > 0) && (pending[0].due == cycle);
    check_value("result_valid_o", 32'(result_valid), 32'(due_now));
    if (due_now) begin
      head = pending.pop_front();
      if (result_valid) begin
        check_value("result_o", 32'(result), 32'(head.result));
        check_value("result_rd_o", 32'(result_rd), 32'(head.rd));
        check_value("flags_o", 32'(flags), 32'(head.flags));
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------

  // outputs settled at the falling edge where inputs change
  task automatic step();
    @(negedge clk);
    cycle++;
    check_outputs();
  endtask

  task automatic idle();
    step();
    instr_valid = 1'b0;
  endtask

  task automatic issue(input alu_op_e op, input logic use_imm, input logic [1:0] rd,
                       input logic [1:0] ra, input logic [1:0] rb, input word_t imm);
    instr_t  word;
    expect_t e;
    word_t   b;
    step();
    word.op      = op;
    word.use_imm = use_imm;
    word.rd      = rd;
    word.ra      = ra;
    word.rb      = rb;
    word.imm     = imm;
    instr        = word;
    instr_valid  = 1'b1;
    // model updated in issue order as the pipeline needs no forwarding
    b = use_imm ? imm : model[rb];
    e = predict(op, model[ra], b, rd);
    pending.push_back(e);
    model[rd] = e.result;
  endtask

  task automatic issue_random();
    issue(alu_op_e'($urandom_range(7, 0)), 1'($urandom_range(1, 0)),
          2'($urandom_range(3, 0)), 2'($urandom_range(3, 0)),
          2'($urandom_range(3, 0)), word_t'($urandom()));
  endtask

  task automatic wait_reset(output logic ok);
    int n;
    n = 0;
    while (rst_n !== 1'b1 && n < Timeout) begin
      @(posedge clk);
      n++;
    end
    ok = (rst_n === 1'b1);
    if (!ok) begin
      $display("timeout: reset was never released");
      timeouts++;
    end
  endtask

  task automatic drain(output logic ok);
    int n;
    n = 0;
    while (pending.size() > 0 && n < Timeout) begin
      idle();
      n++;
    end
    // extra quiet cycles to catch a stray pulse
    repeat (4) idle();
    ok = (pending.size() == 0);
    if (!ok) begin
      $display("timeout: %0d results never came out", pending.size());
      timeouts++;
    end
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    logic ok;
    instr_valid = 1'b0;
    instr       = '0;
    cycle       = '0;
    errors      = 0;
    timeouts    = 0;
    for (int i = 0; i < `ALU_REGS; i++) begin
      model[i] = '0;
    end
    void'($urandom(70));
    wait_reset(ok);
    if (ok) begin
      // registers read back as zero after reset
      for (int i = 0; i < `ALU_REGS; i++) begin
        issue(OP_MOVA, 1'b0, 2'(i), 2'(i), 2'(i), '0);
      end
      // loads at the signed limits
      issue(OP_MOVB, 1'b1, 2'd0, 2'd0, 2'd0, word_t'(MaxVal));
      issue(OP_MOVB, 1'b1, 2'd1, 2'd0, 2'd0, word_t'(1));
      issue(OP_MOVB, 1'b1, 2'd2, 2'd0, 2'd0, word_t'(MinVal));
      issue(OP_MOVB, 1'b1, 2'd3, 2'd0, 2'd0, '0);
      // overflow cases then logic ops and moves on the same values
      issue(OP_ADD, 1'b0, 2'd3, 2'd0, 2'd1, '0);
      issue(OP_SUB, 1'b0, 2'd3, 2'd2, 2'd1, '0);
      issue(OP_INC, 1'b0, 2'd3, 2'd0, 2'd0, '0);
      issue(OP_ADD, 1'b0, 2'd3, 2'd2, 2'd2, '0);
      issue(OP_AND, 1'b0, 2'd3, 2'd0, 2'd2, '0);
      issue(OP_OR, 1'b0, 2'd3, 2'd0, 2'd2, '0);
      issue(OP_XOR, 1'b0, 2'd3, 2'd0, 2'd0, '0);
      issue(OP_MOVA, 1'b0, 2'd3, 2'd2, 2'd0, '0);
      issue(OP_MOVB, 1'b0, 2'd3, 2'd0, 2'd1, '0);
      issue(OP_SUB, 1'b0, 2'd3, 2'd1, 2'd0, '0);
      // each reads the rd written just before it
      issue(OP_MOVB, 1'b1, 2'd3, 2'd0, 2'd0, word_t'(5));
      issue(OP_ADD, 1'b0, 2'd3, 2'd3, 2'd3, '0);
      issue(OP_INC, 1'b0, 2'd3, 2'd3, 2'd0, '0);
      issue(OP_SUB, 1'b0, 2'd0, 2'd3, 2'd1, '0);
      // random mix with roughly one idle cycle in four
      repeat (300) begin
        if ($urandom_range(3, 0) == 0) begin
          idle();
        end
        issue_random();
      end
      drain(ok);
    end
    $display("check errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+.
alu_pkg.sv
cl_adder.sv
alu.sv
instr_decoder.sv
reg_file.sv
exec_stage.sv
result_stage.sv
datapath_top.sv
tb_clkgen.sv
tb_datapath.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_datapath
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Testbench failed" $(LOG); then \
	  echo "simulation FAILED"; exit 1; \
	fi

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
